/* Bender.yml */
package:
  name: core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/bus_pkg.sv
      - hdl/core_ifu.sv
      - hdl/core_idu.sv
      - hdl/core_regfile.sv
      - hdl/core_exu.sv
      - hdl/core_lsu.sv
      - hdl/core_pcu.sv
      - hdl/core_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/core_tb.sv

/* dv/core_tb.sv */
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_tb;

    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    logic                  clock;
    logic                  rst_n;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] inst;
    logic                  mem_req_valid;
    bus_pkg::mem_req_t     mem_req;
    logic                  mem_ok;
    logic [`CORE_XLEN-1:0] mem_rdata;
    logic                  retire;
    logic                  illegal;

    logic [31:0] mem [256];                           // 1 KiB of words.
    integer      seed = 32'h22ae_3be3;
    int          wp;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [3:0]  last_wstrb;

    core_top u_dut (
        .clock(clock), .rst_n(rst_n), .pc(pc), .inst(inst),
        .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_ok(mem_ok),
        .mem_rdata(mem_rdata), .retire(retire), .illegal(illegal)
    );

    always #5 clock = ~clock;

    // ********************************************************************
    // memory model with one access at a time and 1 to 4 cycles of latency
    // ********************************************************************
    always begin : mem_model
        bus_pkg::mem_req_t req;
        int                lat;
        logic [31:0]       rd;
        @(negedge clock);
        if (rst_n && mem_req_valid) begin
            req = mem_req;
            lat = 1 + ({$random(seed)} % 4);
            rd  = mem[req.addr[9:2]];
            if (req.wen) begin
                last_wstrb = req.wstrb;
                for (int b = 0; b < 4; b++) begin
                    if (req.wstrb[b]) begin
                        mem[req.addr[9:2]][8*b +: 8] = req.wdata[8*b +: 8];
                    end
                end
            end
            repeat (lat) @(posedge clock);
            #1;
            mem_ok    = 1'b1;
            mem_rdata = rd;
            @(posedge clock);
            #1;
            mem_ok = 1'b0;
        end
    end

    function automatic logic [31:0] itype(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] rtype(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] stype(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jtype(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // stray fetches halt the core since opcode bits 1:0 are 00.
    function automatic logic [31:0] fill_word(int idx);
        return 32'hee00_0000 | (idx << 2);
    endfunction

    task automatic clear_mem();
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        wp = 0;
    endtask

    task automatic emit(logic [31:0] word);
        mem[wp] = word;
        wp++;
    endtask

    task automatic hold_reset();
        @(posedge clock);
        #1;
        rst_n      = 1'b0;
        last_wstrb = '0;
    endtask

    task automatic release_reset();
        repeat (10) @(posedge clock);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mem(logic [11:0] addr, logic [31:0] exp);
        check_value($sformatf("mem[0x%03h]", addr), mem[addr[9:2]], exp);
    endtask

    task automatic wait_retires(int n);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n && cycles < 400) begin
            @(negedge clock);
            cycles++;
            if (retire) begin
                seen++;
            end
        end
        if (seen < n) begin
            abort_run($sformatf("timeout: only %0d of %0d instructions retired", seen, n));
        end
    endtask

    task automatic end_test(string name, int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("%s: %0d errors", name, errors - errs_before);
    endtask

    // ********************************************************************
    // directed tests
    // ********************************************************************
    task automatic test_reset_fetch();
        logic [31:0] word0;
        int          e0;
        e0    = errors;
        word0 = itype(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd1);
        hold_reset();
        clear_mem();
        emit(word0);
        release_reset();
        @(negedge clock);
        check_value("pc", pc, `CORE_RESET_PC);
        check_value("mem_req_valid", mem_req_valid, 0);
        check_value("retire", retire, 0);
        check_value("illegal", illegal, 0);
        @(negedge clock);                              // first cycle after rst_n rises.
        check_value("mem_req_valid", mem_req_valid, 1);
        check_value("mem_req.addr", mem_req.addr, `CORE_RESET_PC);
        check_value("mem_req.wen", mem_req.wen, 0);
        wait_retires(1);
        check_value("inst", inst, word0);
        end_test("reset_fetch", e0);
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp [7];
        int          e0;
        e0     = errors;
        a      = 32'h0000_0123;
        b      = 32'hffff_fffb;                        // -5.
        exp[0] = a + b;
        exp[1] = a - b;
        exp[2] = a & b;
        exp[3] = a | b;
        exp[4] = a ^ b;
        exp[5] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
        exp[6] = {20'habcde, 12'h000};
        hold_reset();
        clear_mem();
        emit(itype(OPC_IMM, 3'b000, 5'd1, 5'd0, a[11:0]));
        emit(itype(OPC_IMM, 3'b000, 5'd2, 5'd0, b[11:0]));
        emit(rtype(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));  // add.
        emit(rtype(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));  // sub.
        emit(rtype(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        emit(rtype(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        emit(rtype(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        emit(rtype(7'h00, 3'b010, 5'd8, 5'd2, 5'd1));  // slt x8, x2, x1.
        emit(utype(OPC_LUI, 5'd9, 20'habcde));
        for (int r = 3; r <= 9; r++) begin
            emit(stype(5'(r), 5'd0, 12'(32'h200 + 4 * (r - 3))));
        end
        emit(32'h0);
        release_reset();
        wait_retires(16);
        for (int i = 0; i < 7; i++) begin
            check_mem(12'(32'h200 + 4 * i), exp[i]);
        end
        end_test("alu", e0);
    endtask

    task automatic test_load_store();
        logic [31:0] val;
        int          e0;
        e0  = errors;
        val = 32'h1357_92ef;                           // low part has bit 11 clear.
        hold_reset();
        clear_mem();
        emit(utype(OPC_LUI, 5'd1, val[31:12]));
        emit(itype(OPC_IMM, 3'b000, 5'd1, 5'd1, val[11:0]));
        emit(stype(5'd1, 5'd0, 12'h200));
        emit(itype(OPC_LOAD, 3'b010, 5'd2, 5'd0, 12'h200));
        emit(stype(5'd2, 5'd0, 12'h204));
        emit(32'h0);
        release_reset();
        wait_retires(5);
        check_mem(12'h200, val);
        check_mem(12'h204, val);
        check_value("mem_req.wstrb", last_wstrb, 4'hf);
        end_test("load_store", e0);
    endtask

    task automatic test_branch_jump();
        logic [31:0] jal_target;
        logic [31:0] jalr_target;
        int          e0;
        e0          = errors;
        jal_target  = 32'h1c + 32'd12;
        jalr_target = (32'h41 + 32'h0) & ~32'h1;
        hold_reset();
        clear_mem();
        emit(itype(OPC_IMM, 3'b000, 5'd1, 5'd0, 12'd7));
        emit(itype(OPC_IMM, 3'b000, 5'd2, 5'd0, 12'd7));
        emit(itype(OPC_IMM, 3'b000, 5'd3, 5'd0, 12'h055));
        emit(btype(3'b000, 5'd1, 5'd2, 13'd8));        // taken beq skips 0x10.
        emit(stype(5'd3, 5'd0, 12'h200));
        emit(btype(3'b001, 5'd1, 5'd2, 13'd8));        // bne falls through.
        emit(stype(5'd3, 5'd0, 12'h204));
        emit(jtype(5'd4, 21'd12));                     // 0x1c to 0x28.
        emit(stype(5'd3, 5'd0, 12'h208));
        emit(32'h0);
        emit(stype(5'd4, 5'd0, 12'h20c));
        emit(itype(OPC_IMM, 3'b000, 5'd5, 5'd0, 12'h041));
        emit(itype(OPC_JALR, 3'b000, 5'd6, 5'd5, 12'h000));
        emit(32'h0);
        emit(32'h0);
        emit(32'h0);
        emit(stype(5'd6, 5'd0, 12'h210));              // 0x40.
        emit(32'h0);
        release_reset();
        wait_retires(8);
        check_value("pc", pc, jal_target);
        wait_retires(3);
        check_value("pc", pc, jalr_target);
        check_mem(12'h200, fill_word(12'h200 >> 2));
        check_mem(12'h204, 32'h0000_0055);
        check_mem(12'h208, fill_word(12'h208 >> 2));
        check_mem(12'h20c, 32'h1c + 32'd4);
        check_mem(12'h210, 32'h30 + 32'd4);
        end_test("branch_jump", e0);
    endtask

    task automatic test_x0_illegal();
        int cycles;
        int reqs;
        int e0;
        e0 = errors;
        hold_reset();
        clear_mem();
        emit(itype(OPC_IMM, 3'b000, 5'd0, 5'd0, 12'h077));
        emit(stype(5'd0, 5'd0, 12'h200));
        emit(32'hffff_ffff);                           // unknown opcode.
        release_reset();
        wait_retires(2);
        check_mem(12'h200, 32'h0);
        cycles = 0;
        while (!illegal && cycles < 50) begin
            @(negedge clock);
            cycles++;
        end
        if (!illegal) begin
            abort_run("timeout: illegal never went high");
        end
        check_value("pc", pc, 32'h8);
        reqs = 0;
        for (int i = 0; i < 50; i++) begin
            @(negedge clock);
            if (mem_req_valid) begin
                reqs++;
            end
        end
        check_value("mem_req_valid pulses after halt", reqs, 0);
        end_test("x0_illegal", e0);
    endtask

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        mem_ok       = 1'b0;
        mem_rdata    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_wstrb   = '0;
        clear_mem();
        test_reset_fetch();
        test_alu();
        test_load_store();
        test_branch_jump();
        test_x0_illegal();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/bus_pkg.sv */
`include "core_cfg.svh"

package bus_pkg;

    localparam int STRB_W = `CORE_XLEN / 8;

    // ********************************************************************
    // one memory access, valid with the request pulse.
    // ********************************************************************
    typedef struct packed {
        logic [`CORE_XLEN-1:0] addr;
        logic [`CORE_XLEN-1:0] wdata;
        logic [STRB_W-1:0]     wstrb;
        logic                  wen;
    } mem_req_t;

endpackage

/* hdl/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch address.
`define CORE_RESET_PC 32'h0000_0000

// rv32e register count.
`define CORE_NREGS 16

// data and address width.
`define CORE_XLEN 32

`endif

/* hdl/core_exu.sv */
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_exu (
    input  rv_pkg::decoded_t      dec,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_XLEN-1:0] rs1_data,
    input  logic [`CORE_XLEN-1:0] rs2_data,
    output logic [`CORE_XLEN-1:0] alu_result,
    output logic                  take_branch
);

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] alu_out;
    logic                  is_jump;
    logic                  lt;

    assign op_a = dec.src_a_pc  ? pc      : rs1_data;
    assign op_b = dec.src_b_imm ? dec.imm : rs2_data;
    assign lt   = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (dec.alu_op)
            rv_pkg::alu_sub:    alu_out = op_a - op_b;
            rv_pkg::alu_and:    alu_out = op_a & op_b;
            rv_pkg::alu_or:     alu_out = op_a | op_b;
            rv_pkg::alu_xor:    alu_out = op_a ^ op_b;
            rv_pkg::alu_slt:    alu_out = {{(`CORE_XLEN-1){1'b0}}, lt};
            rv_pkg::alu_pass_b: alu_out = op_b;
            default:            alu_out = op_a + op_b;
        endcase
    end

    assign is_jump = (dec.br_kind == rv_pkg::br_jal) || (dec.br_kind == rv_pkg::br_jalr);

    // link address for jumps.
    assign alu_result = is_jump ? pc + 4 : alu_out;

    always_comb begin
        case (dec.br_kind)
            rv_pkg::br_beq:  take_branch = (rs1_data == rs2_data);
            rv_pkg::br_bne:  take_branch = (rs1_data != rs2_data);
            rv_pkg::br_jal:  take_branch = 1'b1;
            rv_pkg::br_jalr: take_branch = 1'b1;
            default:         take_branch = 1'b0;
        endcase
    end

endmodule

/* hdl/core_idu.sv */
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_idu (
    input  logic [`CORE_XLEN-1:0] inst,
    output rv_pkg::decoded_t      dec
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;
    logic [`CORE_XLEN-1:0] imm_b;
    logic [`CORE_XLEN-1:0] imm_u;
    logic [`CORE_XLEN-1:0] imm_j;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  use_rd;
    logic                  bad_op;
    logic                  bad_reg;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // rv32e has no x16..x31.
    assign bad_reg = (use_rs1 && inst[19:15] >= `CORE_NREGS) ||
                     (use_rs2 && inst[24:20] >= `CORE_NREGS) ||
                     (use_rd  && inst[11:7]  >= `CORE_NREGS);

    // ********************************************************************
    // opcode map
    // ********************************************************************
    always_comb begin
        dec         = '0;
        dec.rs1     = inst[18:15];
        dec.rs2     = inst[23:20];
        dec.rd      = inst[10:7];
        dec.alu_op  = rv_pkg::alu_add;
        dec.br_kind = rv_pkg::br_none;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        use_rd      = 1'b0;
        bad_op      = 1'b0;
        case (opcode)
            7'b0110111: begin                          // lui.
                dec.imm = imm_u; dec.alu_op = rv_pkg::alu_pass_b;
                dec.src_b_imm = 1'b1; dec.reg_wen = 1'b1; use_rd = 1'b1;
            end
            7'b0010111: begin                          // auipc.
                dec.imm = imm_u; dec.src_a_pc = 1'b1; dec.src_b_imm = 1'b1;
                dec.reg_wen = 1'b1; use_rd = 1'b1;
            end
            7'b0010011: begin
                dec.imm = imm_i; dec.src_b_imm = 1'b1; dec.reg_wen = 1'b1;
                use_rs1 = 1'b1; use_rd = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = rv_pkg::alu_add;
                    3'b010:  dec.alu_op = rv_pkg::alu_slt;
                    3'b100:  dec.alu_op = rv_pkg::alu_xor;
                    3'b110:  dec.alu_op = rv_pkg::alu_or;
                    3'b111:  dec.alu_op = rv_pkg::alu_and;
                    default: bad_op = 1'b1;
                endcase
            end
            7'b0110011: begin
                dec.reg_wen = 1'b1; use_rs1 = 1'b1; use_rs2 = 1'b1; use_rd = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = rv_pkg::alu_add;
                    10'b0100000_000: dec.alu_op = rv_pkg::alu_sub;
                    10'b0000000_010: dec.alu_op = rv_pkg::alu_slt;
                    10'b0000000_100: dec.alu_op = rv_pkg::alu_xor;
                    10'b0000000_110: dec.alu_op = rv_pkg::alu_or;
                    10'b0000000_111: dec.alu_op = rv_pkg::alu_and;
                    default:         bad_op = 1'b1;
                endcase
            end
            7'b0000011: begin                          // lw only.
                dec.imm = imm_i; dec.src_b_imm = 1'b1; dec.mem_ren = 1'b1;
                dec.reg_wen = 1'b1; use_rs1 = 1'b1; use_rd = 1'b1;
                bad_op = (funct3 != 3'b010);
            end
            7'b0100011: begin                          // sw only.
                dec.imm = imm_s; dec.src_b_imm = 1'b1; dec.mem_wen = 1'b1;
                use_rs1 = 1'b1; use_rs2 = 1'b1;
                bad_op = (funct3 != 3'b010);
            end
            7'b1100011: begin
                dec.imm = imm_b; use_rs1 = 1'b1; use_rs2 = 1'b1;
                case (funct3)
                    3'b000:  dec.br_kind = rv_pkg::br_beq;
                    3'b001:  dec.br_kind = rv_pkg::br_bne;
                    default: bad_op = 1'b1;
                endcase
            end
            7'b1101111: begin
                dec.imm = imm_j; dec.br_kind = rv_pkg::br_jal;
                dec.reg_wen = 1'b1; use_rd = 1'b1;
            end
            7'b1100111: begin
                dec.imm = imm_i; dec.br_kind = rv_pkg::br_jalr;
                dec.reg_wen = 1'b1; use_rs1 = 1'b1; use_rd = 1'b1;
                bad_op = (funct3 != 3'b000);
            end
            default: bad_op = 1'b1;
        endcase
        dec.illegal = bad_op | bad_reg;
    end

endmodule

/* hdl/core_ifu.sv */
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_ifu (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  fetch_done,
    input  logic                  data_done,
    input  logic [`CORE_XLEN-1:0] mem_rdata,
    input  rv_pkg::decoded_t      dec,
    output logic [`CORE_XLEN-1:0] inst,
    output rv_pkg::phase_e        phase,
    output logic                  start_fetch,
    output logic                  commit,
    output logic                  illegal
);

    logic boot;
    logic mem_done;
    logic is_mem;

    assign is_mem = dec.mem_ren | dec.mem_wen;

    always_comb begin
        case (phase)
            rv_pkg::ph_exec: commit = ~dec.illegal & ~is_mem;
            rv_pkg::ph_mem:  commit = mem_done;        // one cycle after mem_ok.
            default:         commit = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= rv_pkg::ph_fetch;
            boot        <= 1'b1;
            start_fetch <= 1'b0;
            mem_done    <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            boot        <= 1'b0;
            start_fetch <= boot | commit;              // first fetch, then one per commit.
            mem_done    <= data_done;
            case (phase)
                rv_pkg::ph_fetch: begin
                    if (fetch_done) begin
                        phase <= rv_pkg::ph_exec;
                    end
                end
                rv_pkg::ph_exec: begin
                    if (dec.illegal) begin
                        illegal <= 1'b1;               // park here for good.
                    end else if (is_mem) begin
                        phase <= rv_pkg::ph_mem;
                    end else begin
                        phase <= rv_pkg::ph_fetch;
                    end
                end
                rv_pkg::ph_mem: begin
                    if (mem_done) begin
                        phase <= rv_pkg::ph_fetch;
                    end
                end
                default: phase <= rv_pkg::ph_fetch;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_done) begin
            inst <= mem_rdata;
        end
    end

endmodule

/* hdl/core_lsu.sv */
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_lsu (
    input  logic                  clock,
    input  logic                  rst_n,
    input  rv_pkg::phase_e        phase,
    input  logic                  start_fetch,
    input  rv_pkg::decoded_t      dec,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_XLEN-1:0] alu_result,
    input  logic [`CORE_XLEN-1:0] rs2_data,
    input  logic                  mem_ok,
    input  logic [`CORE_XLEN-1:0] mem_rdata,
    output logic                  mem_req_valid,
    output bus_pkg::mem_req_t     mem_req,
    output logic                  fetch_done,
    output logic                  data_done,
    output logic [`CORE_XLEN-1:0] load_data
);

    logic fetch_phase;
    logic data_start;
    logic pend_fetch;
    logic pend_data;

    assign fetch_phase = (phase == rv_pkg::ph_fetch);

    // data access goes out in the execute cycle.
    assign data_start = (phase == rv_pkg::ph_exec) & (dec.mem_ren | dec.mem_wen) &
                        ~dec.illegal;

    assign mem_req_valid = start_fetch | data_start;

    // ********************************************************************
    // fetch/data arbiter
    // ********************************************************************
    always_comb begin
        mem_req = '0;
        if (fetch_phase) begin
            mem_req.addr = pc;
        end else begin
            mem_req.addr  = alu_result;
            mem_req.wdata = rs2_data;
            mem_req.wen   = dec.mem_wen;
            mem_req.wstrb = dec.mem_wen ? '1 : '0;    // full words only.
        end
    end

    // owner of the access in flight.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pend_fetch <= 1'b0;
            pend_data  <= 1'b0;
        end else begin
            if (start_fetch) begin
                pend_fetch <= 1'b1;
            end else if (mem_ok) begin
                pend_fetch <= 1'b0;
            end
            if (data_start) begin
                pend_data <= 1'b1;
            end else if (mem_ok) begin
                pend_data <= 1'b0;
            end
        end
    end

    assign fetch_done = mem_ok & pend_fetch;
    assign data_done  = mem_ok & pend_data;

    always_ff @(posedge clock) begin
        if (data_done) begin
            load_data <= mem_rdata;
        end
    end

endmodule

/* hdl/core_pcu.sv */
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_pcu (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  commit,
    input  rv_pkg::decoded_t      dec,
    input  logic [`CORE_XLEN-1:0] rs1_data,
    input  logic                  take_branch,
    output logic [`CORE_XLEN-1:0] pc
);

    logic [`CORE_XLEN-1:0] jalr_sum;
    logic [`CORE_XLEN-1:0] pc_next;

    assign jalr_sum = rs1_data + dec.imm;

    always_comb begin
        if (dec.br_kind == rv_pkg::br_jalr) begin
            pc_next = {jalr_sum[`CORE_XLEN-1:1], 1'b0};   // bit 0 dropped.
        end else if (take_branch) begin
            pc_next = pc + dec.imm;
        end else begin
            pc_next = pc + 4;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
        end else if (commit) begin
            pc <= pc_next;
        end
    end

endmodule

/* hdl/core_regfile.sv */
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_regfile (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  wen,
    input  rv_pkg::decoded_t      dec,
    input  rv_pkg::reg_idx_t      waddr,
    input  logic [`CORE_XLEN-1:0] wdata,
    input  logic [`CORE_XLEN-1:0] load_data,
    input  rv_pkg::reg_idx_t      raddr1,
    input  rv_pkg::reg_idx_t      raddr2,
    output logic [`CORE_XLEN-1:0] rdata1,
    output logic [`CORE_XLEN-1:0] rdata2
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && dec.reg_wen && waddr != '0) begin
            regs[waddr] <= dec.mem_ren ? load_data : wdata;   // loads write memory data.
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* hdl/core_top.sv */
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_top (
    input  logic                  clock,
    input  logic                  rst_n,
    output logic [`CORE_XLEN-1:0] pc,
    output logic [`CORE_XLEN-1:0] inst,
    output logic                  mem_req_valid,
    output bus_pkg::mem_req_t     mem_req,
    input  logic                  mem_ok,
    input  logic [`CORE_XLEN-1:0] mem_rdata,
    output logic                  retire,
    output logic                  illegal
);

    // ********************************************************************
    // internal wires
    // ********************************************************************
    rv_pkg::decoded_t      dec;
    rv_pkg::phase_e        phase;
    logic                  start_fetch;
    logic                  fetch_done;
    logic                  data_done;
    logic [`CORE_XLEN-1:0] load_data;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    logic [`CORE_XLEN-1:0] alu_result;
    logic                  take_branch;

    // the commit pulse is the retire pulse.
    core_ifu u_ifu (
        .clock(clock), .rst_n(rst_n), .fetch_done(fetch_done), .data_done(data_done),
        .mem_rdata(mem_rdata), .dec(dec), .inst(inst), .phase(phase),
        .start_fetch(start_fetch), .commit(retire), .illegal(illegal)
    );

    core_idu u_idu (.inst(inst), .dec(dec));

    core_regfile u_reg (
        .clock(clock), .rst_n(rst_n), .wen(retire), .dec(dec), .waddr(dec.rd),
        .wdata(alu_result), .load_data(load_data), .raddr1(dec.rs1), .raddr2(dec.rs2),
        .rdata1(rs1_data), .rdata2(rs2_data)
    );

    core_exu u_exu (
        .dec(dec), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_result(alu_result), .take_branch(take_branch)
    );

    core_lsu u_lsu (
        .clock(clock), .rst_n(rst_n), .phase(phase), .start_fetch(start_fetch),
        .dec(dec), .pc(pc), .alu_result(alu_result), .rs2_data(rs2_data),
        .mem_ok(mem_ok), .mem_rdata(mem_rdata), .mem_req_valid(mem_req_valid),
        .mem_req(mem_req), .fetch_done(fetch_done), .data_done(data_done),
        .load_data(load_data)
    );

    core_pcu u_pcu (
        .clock(clock), .rst_n(rst_n), .commit(retire), .dec(dec),
        .rs1_data(rs1_data), .take_branch(take_branch), .pc(pc)
    );

endmodule

/* hdl/rv_pkg.sv */
`include "core_cfg.svh"

package rv_pkg;

    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b                       // lui.
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal,
        br_jalr
    } br_kind_e;

    // per-instruction sequencing.
    typedef enum logic [1:0] {
        ph_fetch,
        ph_exec,
        ph_mem
    } phase_e;

    typedef struct packed {
        reg_idx_t              rs1;
        reg_idx_t              rs2;
        reg_idx_t              rd;
        logic [`CORE_XLEN-1:0] imm;
        alu_op_e               alu_op;
        logic                  src_a_pc;   // operand a is the pc.
        logic                  src_b_imm;  // operand b is the immediate.
        logic                  reg_wen;
        logic                  mem_ren;
        logic                  mem_wen;
        br_kind_e              br_kind;
        logic                  illegal;
    } decoded_t;

endpackage

/* vlog.f */
+incdir+hdl
hdl/rv_pkg.sv
hdl/bus_pkg.sv
hdl/core_ifu.sv
hdl/core_idu.sv
hdl/core_regfile.sv
hdl/core_exu.sv
hdl/core_lsu.sv
hdl/core_pcu.sv
hdl/core_top.sv
dv/core_tb.sv
